/* verilog/dmem_pkg.sv */
`default_nettype none

package dmem_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // scalar types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // byte address as issued by the core.
  typedef logic [31:0] byte_addr_t;

  // one data word.
  typedef logic [31:0] word_t;

  // access size.
  typedef enum logic [1:0] {
    MEM_BYTE      = 2'd0,
    MEM_HALF_WORD = 2'd1,
    MEM_WORD      = 2'd2
  } mem_op_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory access
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // one access as seen by the data RAM, 67 bits.
  // write_data sits in the low bits, the RAM shifts it into its lanes.
  typedef struct packed {
    logic       write_enable;
    mem_op_t    mem_op;
    byte_addr_t byte_address;
    word_t      write_data;
  } mem_req_t;

endpackage

`default_nettype wire

/* verilog/data_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module data_memory #(
  parameter int mem_words = 256
) (
  input  logic               clk,
  input  dmem_pkg::mem_req_t mem_req,
  output dmem_pkg::word_t    read_data
);
  import dmem_pkg::*;

  localparam int word_bits = $clog2(mem_words);

  logic [word_bits-1:0] word_index;
  logic [1:0]           byte_offset;
  logic [7:0]           size_mask;
  logic [3:0]           lane_write;
  word_t                shifted_data;
  logic [3:0][7:0]      lane_word;
  logic [63:0]          doubled_word;

  assign word_index  = mem_req.byte_address[word_bits+1:2];
  assign byte_offset = mem_req.byte_address[1:0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // data moves up to the addressed lane.
  assign shifted_data = mem_req.write_data << {byte_offset, 3'b000};

  always_comb begin
    case (mem_req.mem_op)
      MEM_BYTE:      size_mask = 8'b0000_0001;
      MEM_HALF_WORD: size_mask = 8'b0000_0011;
      default:       size_mask = 8'b0000_1111;
    endcase
  end

  // lanes past byte 3 fall off, no wrap into the next word.
  always_comb begin
    logic [7:0] shifted_mask;
    shifted_mask = size_mask << byte_offset;
    lane_write   = shifted_mask[3:0] & {4{mem_req.write_enable}};
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // byte lanes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar lane = 0; lane < 4; lane++) begin : g_lane
    logic [7:0] lane_ram [mem_words];

    always_ff @(posedge clk) begin
      if (lane_write[lane]) begin
        lane_ram[word_index] <= shifted_data[lane*8 +: 8];
      end
    end

    assign lane_word[lane] = lane_ram[word_index];
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // rotate so the addressed byte lands in bits 7:0.
  assign doubled_word = {lane_word, lane_word};
  assign read_data    = doubled_word[{byte_offset, 3'b000} +: 32];

  // upstream control clears on the first reset edge and stays known.
  assert property (@(posedge clk)
    $isunknown($past(mem_req.write_enable)) || !$isunknown(mem_req.write_enable))
    else $error("data_memory: write_enable went unknown");

endmodule

`default_nettype wire

/* verilog/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  logic               clk,
  input  logic               reset,
  input  logic               lsu_req,
  input  logic               copy_req,
  input  dmem_pkg::mem_req_t lsu_mem_req,
  input  dmem_pkg::mem_req_t copy_mem_req,
  output logic               lsu_gnt,
  output logic               copy_gnt,
  output dmem_pkg::mem_req_t mem_req
);

  // set when the load/store unit took the last grant.
  logic last_was_lsu;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // round-robin pick
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // on a tie the peer that did not go last wins.
  assign lsu_gnt  = lsu_req && (!copy_req || !last_was_lsu);
  assign copy_gnt = copy_req && (!lsu_req || last_was_lsu);

  // cleared so the load/store unit goes first after reset.
  always_ff @(posedge clk) begin
    if (reset) begin
      last_was_lsu <= 1'b0;
    end else if (lsu_gnt) begin
      last_was_lsu <= 1'b1;
    end else if (copy_gnt) begin
      last_was_lsu <= 1'b0;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request mux
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    if (lsu_gnt) begin
      mem_req = lsu_mem_req;
    end else begin
      mem_req = copy_mem_req;
    end
    // idle cycle, nothing may be written.
    if (!lsu_gnt && !copy_gnt) begin
      mem_req.write_enable = 1'b0;
    end
  end

  assert property (@(posedge clk) disable iff (reset) !(lsu_gnt && copy_gnt))
    else $error("mem_arbiter: both peers granted");

endmodule

`default_nettype wire

/* verilog/load_store_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 lsu_valid,
  input  logic                 lsu_write,
  input  logic                 lsu_unsigned,
  input  dmem_pkg::mem_op_t    lsu_op,
  input  dmem_pkg::byte_addr_t lsu_addr,
  input  dmem_pkg::word_t      lsu_wdata,
  output dmem_pkg::word_t      lsu_rdata,
  output logic                 lsu_done,
  output logic                 lsu_misaligned,
  output logic                 lsu_req,
  output dmem_pkg::mem_req_t   lsu_mem_req,
  input  logic                 lsu_gnt,
  input  dmem_pkg::word_t      read_data
);
  import dmem_pkg::*;

  logic  misaligned;
  logic  accept;
  logic  held_unsigned;
  word_t load_value;

  // half-words need an even address, words a multiple of 4.
  assign misaligned = ((lsu_op == MEM_HALF_WORD) && lsu_addr[0]) ||
                      ((lsu_op == MEM_WORD) && (lsu_addr[1:0] != 2'b00));
  assign accept     = lsu_valid && !misaligned;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request and completion
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (reset) begin
      lsu_req        <= 1'b0;
      lsu_done       <= 1'b0;
      lsu_misaligned <= 1'b0;
    end else begin
      lsu_done       <= 1'b0;
      lsu_misaligned <= 1'b0;
      if (lsu_req && lsu_gnt) begin
        lsu_req  <= 1'b0;
        lsu_done <= 1'b1;
      end else if (accept) begin
        lsu_req <= 1'b1;
      end else if (lsu_valid) begin
        lsu_misaligned <= 1'b1;
      end
    end
  end

  // held access, steady until the grant.
  always_ff @(posedge clk) begin
    if (accept) begin
      lsu_mem_req <= '{
        write_enable: lsu_write,
        mem_op:       lsu_op,
        byte_address: lsu_addr,
        write_data:   lsu_wdata
      };
      held_unsigned <= lsu_unsigned;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // load extension
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // read data is already rotated, the addressed bytes sit low.
  always_comb begin
    case (lsu_mem_req.mem_op)
      MEM_BYTE:
        load_value = {{24{!held_unsigned && read_data[7]}}, read_data[7:0]};
      MEM_HALF_WORD:
        load_value = {{16{!held_unsigned && read_data[15]}}, read_data[15:0]};
      default:
        load_value = read_data;
    endcase
  end

  always_ff @(posedge clk) begin
    if (lsu_req && lsu_gnt && !lsu_mem_req.write_enable) begin
      lsu_rdata <= load_value;
    end
  end

endmodule

`default_nettype wire

/* verilog/block_copier.sv */
`timescale 1ns/1ps
`default_nettype none

module block_copier #(
  parameter int len_width = 8
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 copy_start,
  input  dmem_pkg::byte_addr_t copy_src,
  input  dmem_pkg::byte_addr_t copy_dst,
  input  logic [len_width-1:0] copy_len,
  output logic                 copy_busy,
  output logic                 copy_done,
  output logic                 copy_req,
  output dmem_pkg::mem_req_t   copy_mem_req,
  input  logic                 copy_gnt,
  input  dmem_pkg::word_t      read_data
);
  import dmem_pkg::*;

  typedef enum logic [1:0] {
    COPY_IDLE,
    COPY_READ,
    COPY_WRITE,
    COPY_FINISH
  } copy_state_t;

  copy_state_t          state;
  byte_addr_t           src_ptr;
  byte_addr_t           dst_ptr;
  logic [len_width-1:0] remaining;
  word_t                word_buf;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // copy FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= COPY_IDLE;
      remaining <= '0;
    end else begin
      case (state)
        COPY_IDLE: begin
          if (copy_start) begin
            remaining <= copy_len;
            state     <= (copy_len == '0) ? COPY_FINISH : COPY_READ;
          end
        end
        COPY_READ: begin
          if (copy_gnt) begin
            state <= COPY_WRITE;
          end
        end
        COPY_WRITE: begin
          if (copy_gnt) begin
            remaining <= remaining - 1'b1;
            state     <= (remaining == len_width'(1)) ? COPY_FINISH : COPY_READ;
          end
        end
        default: state <= COPY_IDLE;
      endcase
    end
  end

  // pointers and the word in flight.
  always_ff @(posedge clk) begin
    case (state)
      COPY_IDLE: begin
        if (copy_start) begin
          src_ptr <= copy_src;
          dst_ptr <= copy_dst;
        end
      end
      COPY_READ: begin
        if (copy_gnt) begin
          word_buf <= read_data;
          src_ptr  <= src_ptr + 32'd4;
        end
      end
      COPY_WRITE: begin
        if (copy_gnt) begin
          dst_ptr <= dst_ptr + 32'd4;
        end
      end
      default: ;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // outputs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign copy_busy = (state != COPY_IDLE);
  assign copy_done = (state == COPY_FINISH);
  assign copy_req  = (state == COPY_READ) || (state == COPY_WRITE);

  // built from registers, so it holds while the grant is pending.
  assign copy_mem_req = '{
    write_enable: (state == COPY_WRITE),
    mem_op:       MEM_WORD,
    byte_address: (state == COPY_WRITE) ? dst_ptr : src_ptr,
    write_data:   word_buf
  };

  assert property (@(posedge clk) disable iff (reset) copy_req |-> copy_busy)
    else $error("block_copier: request outside a copy");

endmodule

`default_nettype wire

/* verilog/dmem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module dmem_subsystem #(
  parameter int mem_words = 256,
  parameter int len_width = 8
) (
  input  logic                 clk,
  input  logic                 reset,
  // load/store port
  input  logic                 lsu_valid,
  input  logic                 lsu_write,
  input  logic                 lsu_unsigned,
  input  dmem_pkg::mem_op_t    lsu_op,
  input  dmem_pkg::byte_addr_t lsu_addr,
  input  dmem_pkg::word_t      lsu_wdata,
  output dmem_pkg::word_t      lsu_rdata,
  output logic                 lsu_done,
  output logic                 lsu_misaligned,
  // block copy port
  input  logic                 copy_start,
  input  dmem_pkg::byte_addr_t copy_src,
  input  dmem_pkg::byte_addr_t copy_dst,
  input  logic [len_width-1:0] copy_len,
  output logic                 copy_busy,
  output logic                 copy_done
);
  import dmem_pkg::*;

  logic     lsu_req;
  logic     lsu_gnt;
  logic     copy_req;
  logic     copy_gnt;
  mem_req_t lsu_mem_req;
  mem_req_t copy_mem_req;
  mem_req_t mem_req;
  word_t    read_data;

  load_store_unit i_lsu (
    .clk            (clk),
    .reset          (reset),
    .lsu_valid      (lsu_valid),
    .lsu_write      (lsu_write),
    .lsu_unsigned   (lsu_unsigned),
    .lsu_op         (lsu_op),
    .lsu_addr       (lsu_addr),
    .lsu_wdata      (lsu_wdata),
    .lsu_rdata      (lsu_rdata),
    .lsu_done       (lsu_done),
    .lsu_misaligned (lsu_misaligned),
    .lsu_req        (lsu_req),
    .lsu_mem_req    (lsu_mem_req),
    .lsu_gnt        (lsu_gnt),
    .read_data      (read_data)
  );

  block_copier #(
    .len_width (len_width)
  ) i_copier (
    .clk          (clk),
    .reset        (reset),
    .copy_start   (copy_start),
    .copy_src     (copy_src),
    .copy_dst     (copy_dst),
    .copy_len     (copy_len),
    .copy_busy    (copy_busy),
    .copy_done    (copy_done),
    .copy_req     (copy_req),
    .copy_mem_req (copy_mem_req),
    .copy_gnt     (copy_gnt),
    .read_data    (read_data)
  );

  mem_arbiter i_arbiter (
    .clk          (clk),
    .reset        (reset),
    .lsu_req      (lsu_req),
    .copy_req     (copy_req),
    .lsu_mem_req  (lsu_mem_req),
    .copy_mem_req (copy_mem_req),
    .lsu_gnt      (lsu_gnt),
    .copy_gnt     (copy_gnt),
    .mem_req      (mem_req)
  );

  data_memory #(
    .mem_words (mem_words)
  ) i_memory (
    .clk       (clk),
    .mem_req   (mem_req),
    .read_data (read_data)
  );

endmodule

`default_nettype wire

/* sim/tb_dmem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dmem_subsystem;
  import dmem_pkg::*;

  localparam int mem_words = 256;
  localparam int len_width = 8;
  localparam int max_ops   = 64;

  logic                 clk;
  logic                 reset;
  logic                 lsu_valid;
  logic                 lsu_write;
  logic                 lsu_unsigned;
  mem_op_t              lsu_op;
  byte_addr_t           lsu_addr;
  word_t                lsu_wdata;
  word_t                lsu_rdata;
  logic                 lsu_done;
  logic                 lsu_misaligned;
  logic                 copy_start;
  byte_addr_t           copy_src;
  byte_addr_t           copy_dst;
  logic [len_width-1:0] copy_len;
  logic                 copy_busy;
  logic                 copy_done;

  logic [31:0] trace [6*max_ops];
  logic [7:0]  model_mem [4*mem_words];
  int          errors = 0;
  int          done_pulses = 0;
  int          watchdog_cycles = 0;

  dmem_subsystem #(
    .mem_words (mem_words),
    .len_width (len_width)
  ) i_dut (
    .clk            (clk),
    .reset          (reset),
    .lsu_valid      (lsu_valid),
    .lsu_write      (lsu_write),
    .lsu_unsigned   (lsu_unsigned),
    .lsu_op         (lsu_op),
    .lsu_addr       (lsu_addr),
    .lsu_wdata      (lsu_wdata),
    .lsu_rdata      (lsu_rdata),
    .lsu_done       (lsu_done),
    .lsu_misaligned (lsu_misaligned),
    .copy_start     (copy_start),
    .copy_src       (copy_src),
    .copy_dst       (copy_dst),
    .copy_len       (copy_len),
    .copy_busy      (copy_busy),
    .copy_done      (copy_done)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(negedge clk) begin
    if (copy_done) begin
      done_pulses <= done_pulses + 1;
    end
  end

  initial begin
    wait (watchdog_cycles != 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog: run still busy after %0d cycles", watchdog_cycles);
    $display("*** FAILED ***");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // aligned means the address is a multiple of the access size in bytes.
  function automatic logic misaligned_access(logic [1:0] size, logic [31:0] addr);
    return (addr % (32'd1 << size)) != 32'd0;
  endfunction

  function automatic void model_store(logic [1:0] size, logic [31:0] addr, word_t data);
    int a;
    a = int'(addr[9:0]);
    for (int i = 0; i < (1 << size); i++) begin
      model_mem[a+i] = data[8*i +: 8];
    end
  endfunction

  // little-endian, sign taken from the top byte of the access.
  function automatic word_t model_load(logic [1:0] size, logic uns, logic [31:0] addr);
    int    a;
    word_t value;
    a = int'(addr[9:0]);
    case (size)
      2'd0:    value = {{24{!uns && model_mem[a][7]}}, model_mem[a]};
      2'd1:    value = {{16{!uns && model_mem[a+1][7]}}, model_mem[a+1], model_mem[a]};
      default: value = {model_mem[a+3], model_mem[a+2], model_mem[a+1], model_mem[a]};
    endcase
    return value;
  endfunction

  task automatic check_value(input string what, input word_t got, input word_t want);
    assert (got === want)
      else begin
        $display("FAIL %0t: %s got 0x%08h, expected 0x%08h", $time, what, got, want);
        errors++;
      end
  endtask

  // one access on the load/store port, back at a falling edge when it ends.
  task automatic lsu_access(input logic wr, input logic [1:0] size, input logic uns,
                            input logic [31:0] addr, input word_t data,
                            output word_t rdata, output logic misal);
    int waited;
    waited = 0;
    @(posedge clk);
    lsu_valid    <= 1'b1;
    lsu_write    <= wr;
    lsu_op       <= mem_op_t'(size);
    lsu_unsigned <= uns;
    lsu_addr     <= addr;
    lsu_wdata    <= data;
    @(posedge clk);
    lsu_valid <= 1'b0;
    @(negedge clk);
    while (!lsu_done && !lsu_misaligned && waited < 40) begin
      @(negedge clk);
      waited++;
    end
    assert (lsu_done || lsu_misaligned)
      else begin
        $display("access at 0x%08h got no completion within 40 cycles", addr);
        errors++;
      end
    rdata = lsu_rdata;
    misal = lsu_misaligned;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // trace run
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    int          ops;
    int          copy_words;
    int          tests;
    int          failed_tests;
    int          errors_before;
    int          pulses_before;
    int          copy_count;
    logic [31:0] kind;
    logic [1:0]  size;
    logic        uns;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expect_col;
    logic [31:0] copy_from;
    logic [31:0] copy_to;
    logic        copy_pending;
    logic        misal;
    word_t       rdata;
    word_t       want;

    reset        = 1'b1;
    lsu_valid    = 1'b0;
    lsu_write    = 1'b0;
    lsu_unsigned = 1'b0;
    lsu_op       = MEM_WORD;
    lsu_addr     = '0;
    lsu_wdata    = '0;
    copy_start   = 1'b0;
    copy_src     = '0;
    copy_dst     = '0;
    copy_len     = '0;
    tests        = 0;
    failed_tests = 0;
    copy_pending = 1'b0;
    void'($urandom(32'h94c7_07d0));

    $readmemh("sim/dmem_trace.txt", trace);
    ops        = 0;
    copy_words = 0;
    while (ops < max_ops - 1 && trace[6*ops] != 32'hf) begin
      if (trace[6*ops] == 32'd2) begin
        copy_words += int'(trace[6*ops+4]);
      end
      ops++;
    end
    if (ops == 0) begin
      $display("no operations found in sim/dmem_trace.txt");
      errors++;
    end
    watchdog_cycles = 20 + mem_words * 8 + ops * 50 + copy_words * 12;

    repeat (10) @(posedge clk);
    reset <= 1'b0;

    for (int w = 0; w < mem_words; w++) begin
      want = $urandom();
      lsu_access(1'b1, 2'd2, 1'b0, 32'(w * 4), want, rdata, misal);
      model_store(2'd2, 32'(w * 4), want);
    end
    $display("memory filled with %0d random words", mem_words);

    for (int i = 0; i < ops; i++) begin
      kind          = trace[6*i];
      size          = trace[6*i+1][1:0];
      uns           = trace[6*i+2][0];
      addr          = trace[6*i+3];
      data          = trace[6*i+4];
      expect_col    = trace[6*i+5];
      errors_before = errors;

      if (kind == 32'd2) begin
        pulses_before = done_pulses;
        copy_from     = addr;
        copy_to       = expect_col;
        copy_count    = int'(data);
        @(posedge clk);
        copy_start <= 1'b1;
        copy_src   <= addr;
        copy_dst   <= expect_col;
        copy_len   <= len_width'(data);
        @(posedge clk);
        copy_start <= 1'b0;
        // bytes move in address order.
        for (int k = 0; k < 4 * copy_count; k++) begin
          model_mem[int'(copy_to[9:0]) + k] = model_mem[int'(copy_from[9:0]) + k];
        end
        copy_pending = 1'b1;
      end else begin
        if (kind == 32'd3) begin
          @(negedge clk);
          assert (copy_busy)
            else begin
              $display("load on trace line %0d was issued with no copy running", i);
              errors++;
            end
        end
        lsu_access(kind == 32'd0, size, uns, addr, data, rdata, misal);
        assert (misal == misaligned_access(size, addr))
          else begin
            $display("FAIL %0t: lsu_misaligned was %0b at address 0x%08h", $time, misal, addr);
            errors++;
          end
        if (!misaligned_access(size, addr)) begin
          if (kind == 32'd0) begin
            model_store(size, addr, data);
          end else begin
            want = model_load(size, uns, addr);
            assert (expect_col == want)
              else begin
                $display("trace line %0d expects 0x%08h but the model gives 0x%08h",
                         i, expect_col, want);
                errors++;
              end
            check_value("load", rdata, want);
          end
        end
      end

      // the copy ends once its overlapping loads are done.
      if (copy_pending && trace[6*(i+1)] != 32'd3) begin
        @(negedge clk);
        while (copy_busy) @(negedge clk);
        assert (done_pulses == pulses_before + 1)
          else begin
            $display("FAIL %0t: copy_done pulsed %0d times for one copy", $time,
                     done_pulses - pulses_before);
            errors++;
          end
        for (int k = 0; k < copy_count; k++) begin
          lsu_access(1'b0, 2'd2, 1'b0, copy_to + 32'(4 * k), '0, rdata, misal);
          check_value("copied word", rdata, model_load(2'd2, 1'b0, copy_to + 32'(4 * k)));
        end
        copy_pending = 1'b0;
      end

      tests++;
      if (errors != errors_before) begin
        failed_tests++;
      end
      $display("test %0d: kind %0d size %0d addr 0x%08h %s", i, kind, size, addr,
               (errors == errors_before) ? "ok" : "failed");
    end

    $display("%0d tests run, %0d failed, %0d check errors", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/dmem_trace.txt */
// columns: kind size unsigned address data expected (kind 0 store, 1 load, 2 copy, 3 load in copy, f end)
// copy lines: address is the source, data the word count, expected the destination
0 2 0 00000010 deadbeef 00000000
0 2 0 00000014 12345678 00000000
1 2 0 00000010 00000000 deadbeef
1 2 0 00000014 00000000 12345678
0 2 0 00000020 11223344 00000000
0 0 0 00000021 123456aa 00000000
0 1 0 00000022 9999bbcc 00000000
1 2 0 00000020 00000000 bbccaa44
0 2 0 00000030 80ff7f01 00000000
1 0 0 00000030 00000000 00000001
1 0 0 00000031 00000000 0000007f
1 0 0 00000032 00000000 ffffffff
1 0 0 00000033 00000000 ffffff80
1 0 1 00000032 00000000 000000ff
1 0 1 00000033 00000000 00000080
1 1 0 00000030 00000000 00007f01
1 1 0 00000032 00000000 ffff80ff
1 1 1 00000032 00000000 000080ff
0 1 0 00000011 0000ffff 00000000
0 2 0 00000016 aaaaaaaa 00000000
1 2 0 00000013 00000000 00000000
1 2 0 00000014 00000000 12345678
1 2 0 00000010 00000000 deadbeef
2 0 0 00000200 00000010 00000300
2 0 0 00000240 00000000 00000380
2 0 0 00000280 00000008 00000340
3 2 0 00000020 00000000 bbccaa44
3 0 1 00000033 00000000 00000080
3 1 0 00000032 00000000 ffff80ff
f 0 0 00000000 00000000 00000000

/* filelist.f */
verilog/dmem_pkg.sv
verilog/data_memory.sv
verilog/mem_arbiter.sv
verilog/load_store_unit.sv
verilog/block_copier.sv
verilog/dmem_subsystem.sv
sim/tb_dmem_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_dmem_subsystem -f filelist.f -o tb_dmem_subsystem

output="$(./obj_dir/tb_dmem_subsystem)"
echo "$output"

if grep -qF '*** PASSED ***' <<< "$output"; then
  exit 0
else
  exit 1
fi
